// ==== ppu_top.f ====
+incdir+include
hw/ppu_pkg.sv
hw/ppu_apb_regs.sv
hw/ppu_frame_ctrl.sv
hw/ppu_raster_counter.sv
hw/ppu_pixel_gen.sv
hw/ppu_top.sv
verif/ppu_assertions.sv
verif/ppu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps --top-module ppu_tb \
	-f ppu_top.f -o ppu_sim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }

# Keep running past assertion errors so the summary line is printed
./obj_dir/ppu_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -qF -- '>>> FAIL' sim.log && { echo "Simulation failed"; exit 1; }
grep -qF -- '>>> PASS' sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// ==== verif/ppu_tb.sv ====
/*
 * Testbench of the raster front end.
 * Programs frames over APB, drains the pixel stream with LFSR-driven
 * ready, predicts every beat from the programmed setup and counts
 * mismatches. Bound assertions watch the stream and the interrupt.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module ppu_tb;

	// Pixels over all frames, sets the cycle budget
	localparam int PIXELS = 15 + 32 + 40 + 36 + 3 * 12;
	localparam int LIMIT = 4 * PIXELS + 2000;

	logic                   clk;
	logic                   rst_n;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [`PPU_W_ADDR-1:0] paddr;
	logic [31:0]            pwdata;
	logic [31:0]            prdata;
	logic                   irq;
	ppu_pkg::ppu_pixel_t    pix;
	logic                   pix_valid;
	logic                   pix_ready = 1'b1;

	// Frame setup as the host programmed it
	ppu_pkg::ppu_mode_e t_mode;
	logic [2:0]         t_shift;
	logic [11:0]        t_w_last;
	logic [11:0]        t_h_last;
	logic [15:0]        t_fg;
	logic [15:0]        t_bg;
	// Next coordinate expected on the stream
	logic [11:0]        exp_x = 12'd0;
	logic [11:0]        exp_y = 12'd0;
	logic [31:0]        lfsr = 32'h706a_4a04;
	logic               ready_random = 1'b0;
	int                 beats = 0;
	int                 beats_base = 0;
	int                 fcount_exp = 0;
	int                 stream_errors = 0;
	int                 run_errors = 0;
	int                 cycles = 0;

	ppu_top dut0 (
		.clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .irq(irq),
		.pix(pix), .pix_valid(pix_valid), .pix_ready(pix_ready)
	);

	bind ppu_top ppu_assertions asrt0 (
		.clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .irq(irq), .start_frame(start_frame),
		.pix(pix), .pix_valid(pix_valid), .pix_ready(pix_ready)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Taps 32 22 2 1, new bit shifted in at the bottom
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [15:0] pattern_color(input logic [11:0] px, input logic [11:0] py);
		logic [11:0] tx;
		logic [11:0] ty;
		logic [12:0] sum;
		tx = px >> t_shift;
		ty = py >> t_shift;
		sum = {1'b0, px} + {1'b0, py};
		case (t_mode)
			ppu_pkg::CHECKER: return (tx[0] ^ ty[0]) ? t_fg : t_bg;
			ppu_pkg::GRAD_X:  return {4'd0, px};
			ppu_pkg::GRAD_XY: return {3'd0, sum};
			default:          return t_fg;
		endcase
	endfunction

	// Prints a Fail line and returns 1 on mismatch
	function automatic bit value_differs(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		if (act_v !== exp_v) begin
			$display("Fail at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
			return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(negedge clk);
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	// Data taken at the ACCESS edge
	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		@(negedge clk);
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		@(posedge clk);
		data = prdata;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic read_check(input string name, input logic [7:0] addr,
			input logic [31:0] exp_v);
		logic [31:0] rd;
		apb_read(addr, rd);
		if (value_differs(name, exp_v, rd))
			run_errors++;
	endtask

	task automatic launch(input ppu_pkg::ppu_mode_e mode, input logic [2:0] shift,
			input logic [11:0] w_last, input logic [11:0] h_last,
			input logic [15:0] fg, input logic [15:0] bg, input logic cont);
		t_mode = mode;
		t_shift = shift;
		t_w_last = w_last;
		t_h_last = h_last;
		t_fg = fg;
		t_bg = bg;
		beats_base = beats;
		apb_write(`PPU_REG_SIZE, {4'd0, h_last, 4'd0, w_last});
		apb_write(`PPU_REG_COLOR, {bg, fg});
		apb_write(`PPU_REG_CTRL, {24'd0, 1'b0, shift, mode, cont, 1'b1});
	endtask

	// Single frame end: irq, idle status, clear, counters
	task automatic finish_frame(input int n_exp);
		while (!irq)
			@(negedge clk);
		fcount_exp++;
		while (pix_valid)
			@(negedge clk);
		read_check("STATUS", `PPU_REG_STATUS, 32'h2);
		apb_write(`PPU_REG_STATUS, 32'h2);
		if (value_differs("irq", 32'h0, 32'(irq)))
			run_errors++;
		read_check("FCOUNT", `PPU_REG_FCOUNT, 32'(fcount_exp));
		if (value_differs("beat count", 32'(n_exp), 32'(beats - beats_base)))
			run_errors++;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sink, scoreboard, watchdog
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(negedge clk) begin
		if (ready_random) begin
			lfsr = lfsr_step(lfsr);
			pix_ready = lfsr[0];
		end else begin
			pix_ready = 1'b1;
		end
	end

	// Row-major order, frames wrap back to 0,0
	always @(posedge clk) begin
		if (rst_n && pix_valid && pix_ready) begin
			if (value_differs("pix.x", 32'(exp_x), 32'(pix.x)))
				stream_errors++;
			if (value_differs("pix.y", 32'(exp_y), 32'(pix.y)))
				stream_errors++;
			if (value_differs("pix.color", 32'(pattern_color(exp_x, exp_y)), 32'(pix.color)))
				stream_errors++;
			if (value_differs("pix.sof", 32'(exp_x == 12'd0 && exp_y == 12'd0), 32'(pix.sof)))
				stream_errors++;
			if (value_differs("pix.eol", 32'(exp_x == t_w_last), 32'(pix.eol)))
				stream_errors++;
			beats++;
			if (exp_x == t_w_last) begin
				exp_x = 12'd0;
				exp_y = (exp_y == t_h_last) ? 12'd0 : exp_y + 12'd1;
			end else begin
				exp_x = exp_x + 12'd1;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		int assert_errors;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;

		// Register readback, unused SIZE bits dropped
		apb_write(`PPU_REG_SIZE, 32'hFABC_F123);
		read_check("SIZE", `PPU_REG_SIZE, 32'h0ABC_0123);
		apb_write(`PPU_REG_COLOR, 32'h1234_ABCD);
		read_check("COLOR", `PPU_REG_COLOR, 32'h1234_ABCD);
		apb_write(`PPU_REG_CTRL, 32'h0000_005E);
		read_check("CTRL", `PPU_REG_CTRL, 32'h0000_005E);
		read_check("unmapped 0x14", 8'h14, 32'h0);
		read_check("unmapped 0x40", 8'h40, 32'h0);

		// Solid 5x3 at full rate, then interrupt handling
		launch(ppu_pkg::SOLID, 3'd0, 12'd4, 12'd2, 16'hF81F, 16'h07E0, 1'b0);
		finish_frame(15);

		// Patterns under random back-pressure
		ready_random = 1'b1;
		launch(ppu_pkg::CHECKER, 3'd1, 12'd7, 12'd3, 16'hFFE0, 16'h001F, 1'b0);
		finish_frame(32);
		launch(ppu_pkg::GRAD_X, 3'd0, 12'd19, 12'd1, 16'h0000, 16'h0000, 1'b0);
		finish_frame(40);
		launch(ppu_pkg::GRAD_XY, 3'd0, 12'd5, 12'd5, 16'h0000, 16'h0000, 1'b0);
		finish_frame(36);

		// Continuous 4x3, stop lands in the third frame
		launch(ppu_pkg::GRAD_XY, 3'd0, 12'd3, 12'd2, 16'h0000, 16'h0000, 1'b1);
		repeat (2) begin
			while (!irq)
				@(negedge clk);
			fcount_exp++;
			apb_write(`PPU_REG_STATUS, 32'h2);
			read_check("FCOUNT", `PPU_REG_FCOUNT, 32'(fcount_exp));
		end
		apb_write(`PPU_REG_CTRL, {24'd0, 1'b1, 3'd0, ppu_pkg::GRAD_XY, 1'b1, 1'b0});
		while (!irq)
			@(negedge clk);
		fcount_exp++;
		apb_write(`PPU_REG_STATUS, 32'h2);
		while (pix_valid)
			@(negedge clk);
		// Quiet gap, no fourth frame may start
		repeat (40) @(negedge clk);
		read_check("STATUS", `PPU_REG_STATUS, 32'h0);
		read_check("FCOUNT", `PPU_REG_FCOUNT, 32'(fcount_exp));
		if (value_differs("beat count", 32'd36, 32'(beats - beats_base)))
			run_errors++;

		assert_errors = dut0.asrt0.fail_count;
		$display("Error counts: stream %0d, control %0d, assertion %0d",
			stream_errors, run_errors, assert_errors);
		if (stream_errors + run_errors + assert_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/ppu_assertions.sv ====
/*
 * Concurrent checks on the raster front end, bound to the top level.
 * Watches the pixel stream under back-pressure, the quiet state in
 * and after reset, and the cause of each interrupt edge.
 * fail_count totals the failed checks for the testbench summary.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module ppu_assertions (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   psel,
	input logic                   penable,
	input logic                   pwrite,
	input logic [`PPU_W_ADDR-1:0] paddr,
	input logic [31:0]            pwdata,
	input logic                   irq,
	input logic                   start_frame,
	input ppu_pkg::ppu_pixel_t    pix,
	input logic                   pix_valid,
	input logic                   pix_ready
);

	int   n_hold = 0;
	int   n_reset = 0;
	int   n_idle = 0;
	int   n_irq = 0;
	int   fail_count;
	// Set by the first CTRL write with the start bit
	logic started;

	assign fail_count = n_hold + n_reset + n_idle + n_irq;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			started <= 1'b0;
		end else if (psel && penable && pwrite && paddr == `PPU_REG_CTRL && pwdata[0]) begin
			started <= 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stream and interrupt
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Stalled beat stays put until taken
	stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		pix_valid && !pix_ready |=> pix_valid && $stable(pix))
		else begin
			n_hold = n_hold + 1;
			$error("pixel beat changed or vanished while stalled");
		end

	// Nothing leaves the block while reset is held
	quiet_in_reset: assert property (@(posedge clk)
		!rst_n |-> !pix_valid && !irq)
		else begin
			n_reset = n_reset + 1;
			$error("pix_valid or irq active during reset");
		end

	// Still quiet until the host starts a frame
	quiet_before_start: assert property (@(posedge clk) disable iff (!rst_n)
		!started |-> !pix_valid && !irq)
		else begin
			n_idle = n_idle + 1;
			$error("pix_valid or irq active before the first start");
		end

	// Only a frame end raises irq, two cycles after the counter wraps
	irq_from_frame_end: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(irq) |-> $past(start_frame, 2))
		else begin
			n_irq = n_irq + 1;
			$error("irq rose without a frame end");
		end

endmodule

`default_nettype wire

// ==== hw/ppu_top.sv ====
/*
 * Raster front end top level.
 * APB register block, frame sequencer, raster counter and pattern
 * generator wired together. The host programs and starts frames over
 * APB, and pixels leave on the valid/ready stream.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module ppu_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`PPU_W_ADDR-1:0] paddr,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   irq,
	output ppu_pkg::ppu_pixel_t    pix,
	output logic                   pix_valid,
	input  logic                   pix_ready
);

	ppu_pkg::ppu_cfg_t       cfg;
	logic                    start;
	logic                    stop;
	logic                    busy;
	logic                    frame_done;
	logic                    clr;
	logic                    run;
	logic                    step;
	logic [`PPU_W_COORD-1:0] x;
	logic [`PPU_W_COORD-1:0] y;
	logic                    start_frame;

	ppu_apb_regs regs0 (
		.clk(clk), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.cfg(cfg), .start(start), .stop(stop),
		.busy(busy), .frame_done(frame_done), .irq(irq)
	);

	ppu_frame_ctrl ctrl0 (
		.clk(clk), .rst_n(rst_n), .cfg(cfg),
		.start(start), .stop(stop), .start_frame(start_frame),
		.clr(clr), .run(run), .busy(busy), .frame_done(frame_done)
	);

	// Steps only when the generator takes a coordinate
	ppu_raster_counter cnt0 (
		.clk(clk), .rst_n(rst_n), .step(step), .clr(clr),
		.w_last(cfg.w_last), .h_last(cfg.h_last), .x(x), .y(y),
		.start_row(), .start_frame(start_frame)
	);

	ppu_pixel_gen gen0 (
		.clk(clk), .rst_n(rst_n), .run(run), .cfg(cfg), .x(x), .y(y),
		.step(step), .pix(pix), .pix_valid(pix_valid), .pix_ready(pix_ready)
	);

endmodule

`default_nettype wire

// ==== hw/ppu_pixel_gen.sv ====
/*
 * Pattern generator with a one-entry output register.
 * Turns the raster coordinate into an RGB565 colour by the selected
 * mode, tags sof and eol and presents the beat on a valid/ready
 * stream. The register takes a new coordinate only when it is empty
 * or draining, and that same condition steps the raster counter.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module ppu_pixel_gen (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    run,
	input  ppu_pkg::ppu_cfg_t       cfg,
	input  logic [`PPU_W_COORD-1:0] x,
	input  logic [`PPU_W_COORD-1:0] y,
	output logic                    step,
	output ppu_pkg::ppu_pixel_t     pix,
	output logic                    pix_valid,
	input  logic                    pix_ready
);

	localparam int W_COL = `PPU_W_COLOR;

	// One carry bit above the coordinate
	logic [`PPU_W_COORD:0] xy_sum;
	logic                  tile_odd;
	logic [W_COL-1:0]      color_d;
	ppu_pkg::ppu_pixel_t   pix_d;
	logic                  load;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Colour
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign xy_sum = x + y;
	// Checkerboard parity of the tile column and tile row
	assign tile_odd = x[cfg.tile_shift] ^ y[cfg.tile_shift];

	always_comb begin
		case (cfg.mode)
			ppu_pkg::SOLID:   color_d = cfg.fg;
			ppu_pkg::CHECKER: color_d = tile_odd ? cfg.fg : cfg.bg;
			// Gradients are the coordinate fitted to the colour width
			ppu_pkg::GRAD_X:  color_d = W_COL'(x);
			ppu_pkg::GRAD_XY: color_d = W_COL'(xy_sum);
			default:          color_d = cfg.fg;
		endcase
	end

	always_comb begin
		pix_d.x     = x;
		pix_d.y     = y;
		pix_d.color = color_d;
		pix_d.sof   = (x == '0) && (y == '0);
		pix_d.eol   = (x == cfg.w_last);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Slot free now or freed by a beat at this edge
	assign load = !pix_valid || pix_ready;
	assign step = run && load;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix_valid <= 1'b0;
		end else if (load) begin
			pix_valid <= run;
		end
	end

	// Payload only moves with a step, so it holds under back-pressure
	always_ff @(posedge clk) begin
		if (step) begin
			pix <= pix_d;
		end
	end

endmodule

`default_nettype wire

// ==== hw/ppu_raster_counter.sv ====
/*
 * Row-major x/y raster counter.
 * Advances one coordinate per step, wraps x at w_last and y at
 * h_last. Clear wins over step. Row and frame wrap come out as
 * registered pulses, low while idle or clearing.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module ppu_raster_counter (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    step,
	input  logic                    clr,
	input  logic [`PPU_W_COORD-1:0] w_last,
	input  logic [`PPU_W_COORD-1:0] h_last,
	output logic [`PPU_W_COORD-1:0] x,
	output logic [`PPU_W_COORD-1:0] y,
	output logic                    start_row,
	output logic                    start_frame
);

	logic x_end;
	logic y_end;

	// Current position is the last column / last row
	assign x_end = (x == w_last);
	assign y_end = (y == h_last);

	// Coordinate registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			x <= '0;
			y <= '0;
		end else if (clr) begin
			x <= '0;
			y <= '0;
		end else if (step) begin
			x <= x_end ? '0 : x + 1'b1;
			if (x_end) begin
				// Bottom-right corner wraps the whole frame
				y <= y_end ? '0 : y + 1'b1;
			end
		end
	end

	// Wrap pulses, aligned with the coordinate update
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			start_row   <= 1'b0;
			start_frame <= 1'b0;
		end else begin
			start_row   <= step && !clr && x_end;
			start_frame <= step && !clr && x_end && y_end;
		end
	end

endmodule

`default_nettype wire

// ==== hw/ppu_frame_ctrl.sv ====
/*
 * Frame sequencer of the raster front end.
 * Clears the raster counter before each frame, runs it until the
 * frame wrap comes back, then signals frame done for one cycle and
 * either stops or loops into the next frame in continuous mode.
 */

`timescale 1ns/1ps
`default_nettype none

module ppu_frame_ctrl (
	input  logic              clk,
	input  logic              rst_n,
	input  ppu_pkg::ppu_cfg_t cfg,
	input  logic              start,
	input  logic              stop,
	input  logic              start_frame,
	output logic              clr,
	output logic              run,
	output logic              busy,
	output logic              frame_done
);

	ppu_pkg::ppu_state_e state_q;
	ppu_pkg::ppu_state_e state_d;
	// Latched continuous mode
	logic                cont_q;
	// High only in the CLEAR cycle right after a start from IDLE
	logic                arm_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Next state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		state_d = state_q;
		case (state_q)
			// Start outside IDLE is ignored
			ppu_pkg::IDLE:   if (start) state_d = ppu_pkg::CLEAR;
			ppu_pkg::CLEAR:  state_d = ppu_pkg::ACTIVE;
			// Last coordinate went out one cycle ago
			ppu_pkg::ACTIVE: if (start_frame) state_d = ppu_pkg::DONE;
			// A stop arriving right now still ends the loop
			ppu_pkg::DONE:   state_d = (cont_q && !stop) ? ppu_pkg::CLEAR : ppu_pkg::IDLE;
			default:         state_d = ppu_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ppu_pkg::IDLE;
			arm_q   <= 1'b0;
			cont_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			arm_q   <= (state_q == ppu_pkg::IDLE) && start;
			// CTRL lands in cfg on the start edge, so sample one cycle later
			if (stop) begin
				cont_q <= 1'b0;
			end else if (arm_q) begin
				cont_q <= cfg.continuous;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Outputs
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign clr = (state_q == ppu_pkg::CLEAR);
	// Counter already wrapped to 0,0 in the start_frame cycle, hold it there
	assign run = (state_q == ppu_pkg::ACTIVE) && !start_frame;
	assign busy = (state_q != ppu_pkg::IDLE);
	assign frame_done = (state_q == ppu_pkg::DONE);

endmodule

`default_nettype wire

// ==== hw/ppu_apb_regs.sv ====
/*
 * APB slave of the raster front end, zero wait states.
 * Holds frame size, colours and pattern setup, turns CTRL writes into
 * start and stop pulses, keeps the sticky frame-done interrupt and
 * the completed-frame counter. Unmapped offsets read as zero.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module ppu_apb_regs (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`PPU_W_ADDR-1:0] paddr,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output ppu_pkg::ppu_cfg_t      cfg,
	output logic                   start,
	output logic                   stop,
	input  logic                   busy,
	input  logic                   frame_done,
	output logic                   irq
);

	// Zero padding above a coordinate in the 16-bit SIZE halves
	localparam int W_PAD = 16 - `PPU_W_COORD;

	logic        wr_en;
	logic        wr_ctrl;
	logic        wr_size;
	logic        wr_color;
	logic        wr_status;
	logic [15:0] fcount;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Writes land on the ACCESS edge
	assign wr_en     = psel & penable & pwrite;
	assign wr_ctrl   = wr_en && (paddr == `PPU_REG_CTRL);
	assign wr_size   = wr_en && (paddr == `PPU_REG_SIZE);
	assign wr_color  = wr_en && (paddr == `PPU_REG_COLOR);
	assign wr_status = wr_en && (paddr == `PPU_REG_STATUS);

	// Command bits never stored, one-cycle pulses straight from the bus
	assign start = wr_ctrl & pwdata[0];
	assign stop  = wr_ctrl & pwdata[7];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg <= '0;
		end else begin
			if (wr_ctrl) begin
				cfg.continuous <= pwdata[1];
				cfg.mode       <= ppu_pkg::ppu_mode_e'(pwdata[3:2]);
				cfg.tile_shift <= pwdata[6:4];
			end
			if (wr_size) begin
				cfg.w_last <= pwdata[0 +: `PPU_W_COORD];
				cfg.h_last <= pwdata[16 +: `PPU_W_COORD];
			end
			// fg low half, bg high half
			if (wr_color) begin
				cfg.fg <= pwdata[0 +: `PPU_W_COLOR];
				cfg.bg <= pwdata[16 +: `PPU_W_COLOR];
			end
		end
	end

	// Sticky done flag, a new frame end beats a clear in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq <= 1'b0;
		end else if (frame_done) begin
			irq <= 1'b1;
		end else if (wr_status && pwdata[1]) begin
			irq <= 1'b0;
		end
	end

	// Frames completed since reset, wraps at 16 bits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fcount <= 16'd0;
		end else if (frame_done) begin
			fcount <= fcount + 16'd1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read mux
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		prdata = 32'd0;
		if (psel && !pwrite) begin
			case (paddr)
				// Start and stop read back as zero
				`PPU_REG_CTRL:   prdata = {25'd0, cfg.tile_shift, cfg.mode, cfg.continuous, 1'b0};
				`PPU_REG_SIZE:   prdata = {{W_PAD{1'b0}}, cfg.h_last, {W_PAD{1'b0}}, cfg.w_last};
				`PPU_REG_COLOR:  prdata = {cfg.bg, cfg.fg};
				`PPU_REG_STATUS: prdata = {30'd0, irq, busy};
				`PPU_REG_FCOUNT: prdata = {16'd0, fcount};
				default:         prdata = 32'd0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/ppu_pkg.sv ====
/*
 * Shared types of the raster front end.
 * Pattern and controller state encodings, the configuration bundle
 * from the register block and the pixel beat on the output stream.
 * Referenced by scoped name from each module.
 */

`default_nettype none

`include "ppu_cfg.svh"

package ppu_pkg;

	// Pattern opcode, CTRL bits 3:2
	typedef enum logic [1:0] {
		SOLID   = 2'd0,
		CHECKER = 2'd1,
		GRAD_X  = 2'd2,
		GRAD_XY = 2'd3
	} ppu_mode_e;

	// Frame controller states
	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		CLEAR  = 2'd1,
		ACTIVE = 2'd2,
		DONE   = 2'd3
	} ppu_state_e;

	// Programmed frame setup
	typedef struct packed {
		logic [`PPU_W_COORD-1:0] w_last;
		logic [`PPU_W_COORD-1:0] h_last;
		ppu_mode_e               mode;
		// Tile edge is 2^tile_shift pixels
		logic [2:0]              tile_shift;
		logic [`PPU_W_COLOR-1:0] fg;
		logic [`PPU_W_COLOR-1:0] bg;
		logic                    continuous;
	} ppu_cfg_t;

	// One beat of the pixel stream
	typedef struct packed {
		logic [`PPU_W_COORD-1:0] x;
		logic [`PPU_W_COORD-1:0] y;
		logic [`PPU_W_COLOR-1:0] color;
		logic                    sof;
		logic                    eol;
	} ppu_pixel_t;

endpackage

`default_nettype wire

// ==== include/ppu_cfg.svh ====
/*
 * Build-time widths and APB register map of the pixel front end.
 * Include wherever coordinate, colour or address widths are needed.
 * The package carries the matching types.
 */

`ifndef PPU_CFG_SVH
`define PPU_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Raster coordinate, up to 4096 columns or rows
`define PPU_W_COORD 12
// One RGB565 pixel
`define PPU_W_COLOR 16
// APB byte address
`define PPU_W_ADDR 8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register byte offsets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define PPU_REG_CTRL 8'h00
`define PPU_REG_SIZE 8'h04
`define PPU_REG_COLOR 8'h08
`define PPU_REG_STATUS 8'h0C
// Completed-frame count, read only
`define PPU_REG_FCOUNT 8'h10

`endif
